// ==== tb.f ====
+incdir+common
common/soc_pkg.sv
source/addr_decoder.sv
source/bus_ctrl_fsm.sv
source/debug_req_gate.sv
clint/clint_timer.sv
memory/boot_rom.sv
memory/scratchpad_mem.sv
source/soc_subsystem.sv
test/soc_assert.sv
test/soc_checker.sv
test/tb_soc_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
  --top-module tb_soc_subsystem -f tb.f -o Vtb_soc_subsystem
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_soc_subsystem > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TB FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0

// ==== test/tb_soc_subsystem.sv ====
`timescale 1ns/10ps
`include "soc_config.svh"

module tb_soc_subsystem;
  import soc_pkg::*;

  localparam int MAX_CYCLES = 3000;

  logic                      clk_i;
  logic                      ndmreset_n;
  logic                      req_valid_i;
  bus_req_t                  req_i;
  logic                      ready_o;
  logic                      rsp_valid_o;
  bus_rsp_t                  rsp_o;
  logic                      rtc_i;
  logic [`SOC_NUM_HARTS-1:0] debug_req_i;
  logic [`SOC_NUM_HARTS-1:0] timer_irq_o;
  logic [`SOC_NUM_HARTS-1:0] debug_req_o;
  logic [2:0]                test_id;
  int                        chk_err;
  int                        tb_err;
  int                        cycles;
  int                        rel_cnt;
  int                        seed;

  soc_subsystem dut_i (.*);

  soc_checker u_checker (
    .clk_i(clk_i), .ndmreset_n(ndmreset_n), .req_valid_i(req_valid_i), .req_i(req_i),
    .ready_i(ready_o), .rsp_valid_i(rsp_valid_o), .rsp_i(rsp_o), .rtc_i(rtc_i),
    .test_id_i(test_id), .err_cnt_o(chk_err)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  initial begin
    rtc_i = 1'b0;
    forever begin
      repeat (5) @(posedge clk_i);
      rtc_i <= ~rtc_i;
    end
  end

  // Timeout and debug hold-off watch
  always @(posedge clk_i) begin
    cycles++;
    if (ndmreset_n) begin
      rel_cnt++;
      if (debug_req_o !== ((rel_cnt <= `SOC_DMI_DEL_CYCLES) ? '0 : debug_req_i)) begin
        $display("Mismatch test=debug_hold_off edge=%0d expected=%b actual=%b", rel_cnt,
                 (rel_cnt <= `SOC_DMI_DEL_CYCLES) ? '0 : debug_req_i, debug_req_o);
        tb_err++;
      end
    end
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic bus_xfer(input logic we, input logic [`SOC_ADDR_W-1:0] addr,
                          input logic [`SOC_DATA_W-1:0] wdata, input logic [`SOC_BE_W-1:0] be,
                          output logic [`SOC_DATA_W-1:0] rdata);
    bus_req_t r;
    r = '{we: we, addr: addr, wdata: wdata, be: be};
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_i       <= r;
    do @(posedge clk_i); while (!ready_o);
    req_valid_i <= 1'b0;
    do @(posedge clk_i); while (!rsp_valid_o);
    rdata = rsp_o.rdata;
  endtask

  initial begin
    logic [`SOC_DATA_W-1:0] rd;
    logic [`SOC_DATA_W-1:0] mt;
    int                     waited;
    seed = 32'h4021;
    cycles = 0;
    rel_cnt = 0;
    tb_err = 0;
    ndmreset_n = 1'b0;
    req_valid_i = 1'b0;
    req_i = '0;
    debug_req_i = '1;
    test_id = 3'd1;
    repeat (10) @(posedge clk_i);
    ndmreset_n <= 1'b1;
    @(posedge clk_i);
    if (timer_irq_o !== '0) begin
      $display("Timer interrupt high after reset");
      tb_err++;
    end

    // ------------------------------
    // Boot ROM
    // ------------------------------
    test_id <= 3'd2;
    for (int i = 0; i < `SOC_ROM_WORDS; i++) bus_xfer(1'b0, `SOC_ROM_BASE + 8*i, '0, '0, rd);
    bus_xfer(1'b1, `SOC_ROM_BASE + 8, {$random(seed), $random(seed)}, '1, rd);
    bus_xfer(1'b0, `SOC_ROM_BASE + 8, '0, '0, rd);

    // ------------------------------
    // Scratchpad
    // ------------------------------
    test_id <= 3'd3;
    // Known contents for the words used below
    for (int i = 0; i < 32; i++) begin
      bus_xfer(1'b1, `SOC_SPM_BASE + 8*i, {$random(seed), $random(seed)}, '1, rd);
    end
    for (int i = 0; i < 200; i++) begin
      bus_xfer($random(seed) & 1, `SOC_SPM_BASE + 8*($random(seed) & 31),
               {$random(seed), $random(seed)}, $random(seed) & 8'hFF, rd);
    end

    test_id <= 3'd4;
    // Last word of the window gets a known value
    bus_xfer(1'b1, `SOC_SPM_BASE + `SOC_SPM_LEN - 8, 64'h5A5A_0F0F_A5A5_F0F0, '1, rd);
    bus_xfer(1'b0, 32'h3000_0000, '0, '0, rd);
    bus_xfer(1'b1, `SOC_SPM_BASE + `SOC_SPM_LEN, 64'h1111_2222_3333_4444, '1, rd);
    bus_xfer(1'b0, `SOC_SPM_BASE + `SOC_SPM_LEN - 8, '0, '0, rd);
    bus_xfer(1'b0, `SOC_SPM_BASE, '0, '0, rd);

    // ------------------------------
    // Timer
    // ------------------------------
    test_id <= 3'd5;
    bus_xfer(1'b0, `SOC_CLINT_BASE, '0, '0, mt);
    bus_xfer(1'b1, `SOC_CLINT_BASE + 8, mt + 2, '0, rd);
    bus_xfer(1'b0, `SOC_CLINT_BASE + 8, '0, '0, rd);
    if (timer_irq_o !== '0) begin
      $display("Timer interrupt high before mtime reached mtimecmp");
      tb_err++;
    end
    waited = 0;
    while (timer_irq_o !== '1 && waited < 40) begin
      @(posedge clk_i);
      waited++;
    end
    if (timer_irq_o !== '1) begin
      $display("Timer interrupt did not rise within 40 cycles");
      tb_err++;
    end
    bus_xfer(1'b1, `SOC_CLINT_BASE + 8, '1, '0, rd);
    @(posedge clk_i);
    if (timer_irq_o !== '0) begin
      $display("Timer interrupt still high after mtimecmp was set to all ones");
      tb_err++;
    end

    while (rel_cnt < `SOC_DMI_DEL_CYCLES + 20) @(posedge clk_i);
    repeat (2) @(posedge clk_i);
    $display("Errors: checker %0d, testbench %0d", chk_err, tb_err);
    if (chk_err == 0 && tb_err == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== test/soc_checker.sv ====
`timescale 1ns/10ps
`include "soc_config.svh"

module soc_checker (
  input  logic              clk_i,
  input  logic              ndmreset_n,
  input  logic              req_valid_i,
  input  soc_pkg::bus_req_t req_i,
  input  logic              ready_i,
  input  logic              rsp_valid_i,
  input  soc_pkg::bus_rsp_t rsp_i,
  input  logic              rtc_i,
  input  logic [2:0]        test_id_i,
  output int                err_cnt_o
);
  import soc_pkg::*;

  logic [`SOC_DATA_W-1:0] spm_model [`SOC_SPM_WORDS];
  logic [`SOC_DATA_W-1:0] mtimecmp_model;
  int                     rtc_rises;
  logic                   rtc_prev;
  int                     pend;
  bus_req_t               req_q;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd2:    return "boot_rom";
      3'd3:    return "scratchpad";
      3'd4:    return "decode_miss";
      3'd5:    return "timer";
      default: return "other";
    endcase
  endfunction

  // Target of an address from the map, -1 on a miss
  function automatic int rule_of(input logic [`SOC_ADDR_W-1:0] a);
    logic [`SOC_ADDR_W-1:0] wa;
    wa = a & ~`SOC_ADDR_W'(7);
    for (int i = 0; i < NUM_RULES; i++) begin
      if (wa >= addr_map[i].start_addr && wa < addr_map[i].end_addr) begin
        return int'(addr_map[i].idx);
      end
    end
    return -1;
  endfunction

  // Expected response from the address map, ROM table and models
  function automatic bus_rsp_t expected_rsp(input bus_req_t r);
    bus_rsp_t e;
    int       t;
    e = '0;
    t = rule_of(r.addr);
    if (t < 0) begin
      e.err = 1'b1;
    end else if (!r.we) begin
      case (t)
        int'(TGT_ROM):   e.rdata = boot_rom_table[(r.addr - `SOC_ROM_BASE) >> 3];
        int'(TGT_CLINT): e.rdata = r.addr[3] ? mtimecmp_model : '0;
        default:         e.rdata = spm_model[(r.addr - `SOC_SPM_BASE) >> 3];
      endcase
    end
    return e;
  endfunction

  task automatic compare_rsp();
    bus_rsp_t exp;
    int       t;
    longint   e_mt;
    exp = expected_rsp(req_q);
    t = rule_of(req_q.addr);
    if (t == int'(TGT_CLINT) && !req_q.we && !req_q.addr[3]) begin
      // mtime runs at half the RTC rate, sync delay allows one count of slack
      e_mt = rtc_rises / 2;
      if (rsp_i.err || longint'(rsp_i.rdata) + 1 < e_mt || longint'(rsp_i.rdata) > e_mt + 1) begin
        $display("Mismatch test=%s mtime expected=%0d+-1 actual=%0d err=%0b",
                 test_name(test_id_i), e_mt, rsp_i.rdata, rsp_i.err);
        err_cnt_o++;
      end
    end else if (rsp_i !== exp) begin
      $display("Mismatch test=%s addr=%h expected=%h/%0b actual=%h/%0b", test_name(test_id_i),
               req_q.addr, exp.rdata, exp.err, rsp_i.rdata, rsp_i.err);
      err_cnt_o++;
    end
    if (t >= 0 && req_q.we) begin
      if (t == int'(TGT_SPM)) begin
        for (int b = 0; b < `SOC_BE_W; b++) begin
          if (req_q.be[b]) begin
            spm_model[(req_q.addr - `SOC_SPM_BASE) >> 3][8*b +: 8] = req_q.wdata[8*b +: 8];
          end
        end
      end else if (t == int'(TGT_CLINT) && req_q.addr[3]) begin
        mtimecmp_model = req_q.wdata;
      end
    end
  endtask

  initial err_cnt_o = 0;

  // ------------------------------
  // Response timing and compare
  // ------------------------------
  always @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      pend = 0;
      rtc_rises = 0;
      rtc_prev = 1'b0;
      mtimecmp_model = '1;
    end else begin
      if (rtc_i && !rtc_prev) rtc_rises++;
      rtc_prev = rtc_i;
      case (pend)
        2: begin
          if (!rsp_valid_i) begin
            $display("No response at the second edge after acceptance (%s)",
                     test_name(test_id_i));
            err_cnt_o++;
          end else begin
            compare_rsp();
          end
          pend = 0;
        end
        1: begin
          if (rsp_valid_i || ready_i) begin
            $display("Ready or response high one edge after acceptance (%s)",
                     test_name(test_id_i));
            err_cnt_o++;
          end
          pend = 2;
        end
        default: begin
          if (rsp_valid_i) begin
            $display("Response seen without an accepted request (%s)",
                     test_name(test_id_i));
            err_cnt_o++;
          end
        end
      endcase
      if (pend == 0 && ready_i && req_valid_i) begin
        req_q = req_i;
        pend = 1;
      end
    end
  end

endmodule

// ==== test/soc_assert.sv ====
`timescale 1ns/10ps
`include "soc_config.svh"

module soc_assert (
  input logic                      clk_i,
  input logic                      ndmreset_n,
  input logic                      ready_o,
  input logic                      rsp_valid_o,
  input logic [`SOC_NUM_HARTS-1:0] debug_req_o
);

  int unsigned hold_cnt;

  // Edges seen since reset release, saturating past the hold-off
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      hold_cnt <= 0;
    end else if (hold_cnt <= `SOC_DMI_DEL_CYCLES) begin
      hold_cnt <= hold_cnt + 1;
    end
  end

  rsp_single_cycle: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    rsp_valid_o |=> !rsp_valid_o) else $error("rsp_valid_o high two cycles in a row");

  rsp_not_ready: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    rsp_valid_o |-> !ready_o) else $error("ready_o high during a response");

  debug_hold_off: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (hold_cnt < `SOC_DMI_DEL_CYCLES) |-> (debug_req_o == '0))
    else $error("debug_req_o nonzero during the hold-off");

endmodule

bind soc_subsystem soc_assert u_soc_assert (
  .clk_i       ( clk_i       ),
  .ndmreset_n  ( ndmreset_n  ),
  .ready_o     ( ready_o     ),
  .rsp_valid_o ( rsp_valid_o ),
  .debug_req_o ( debug_req_o )
);

// ==== source/soc_subsystem.sv ====
`timescale 1ns/10ps
`include "soc_config.svh"

module soc_subsystem (
  input  logic                        clk_i,
  input  logic                        ndmreset_n,
  input  logic                        req_valid_i,
  input  soc_pkg::bus_req_t           req_i,
  output logic                        ready_o,
  output logic                        rsp_valid_o,
  output soc_pkg::bus_rsp_t           rsp_o,
  input  logic                        rtc_i,
  input  logic [`SOC_NUM_HARTS-1:0]   debug_req_i,
  output logic [`SOC_NUM_HARTS-1:0]   timer_irq_o,
  output logic [`SOC_NUM_HARTS-1:0]   debug_req_o
);
  import soc_pkg::*;

  target_e                dec_target;
  logic                   dec_hit;
  bus_req_t               tgt_req;
  logic                   rom_req;
  logic                   clint_req;
  logic                   spm_req;
  logic [`SOC_DATA_W-1:0] rom_rdata;
  logic [`SOC_DATA_W-1:0] clint_rdata;
  logic [`SOC_DATA_W-1:0] spm_rdata;

  // ------------------------------
  // Bus front end
  // ------------------------------
  addr_decoder i_addr_decoder (
    .addr_i   ( req_i.addr ),
    .target_o ( dec_target ),
    .hit_o    ( dec_hit    )
  );

  bus_ctrl_fsm i_bus_ctrl_fsm (
    .clk_i         ( clk_i       ),
    .ndmreset_n    ( ndmreset_n  ),
    .req_valid_i   ( req_valid_i ),
    .req_i         ( req_i       ),
    .target_i      ( dec_target  ),
    .hit_i         ( dec_hit     ),
    .rom_rdata_i   ( rom_rdata   ),
    .clint_rdata_i ( clint_rdata ),
    .spm_rdata_i   ( spm_rdata   ),
    .ready_o       ( ready_o     ),
    .rsp_valid_o   ( rsp_valid_o ),
    .rsp_o         ( rsp_o       ),
    .tgt_req_o     ( tgt_req     ),
    .rom_req_o     ( rom_req     ),
    .clint_req_o   ( clint_req   ),
    .spm_req_o     ( spm_req     )
  );

  // ------------------------------
  // Targets
  // ------------------------------
  boot_rom i_boot_rom (
    .clk_i   ( clk_i        ),
    .req_i   ( rom_req      ),
    .addr_i  ( tgt_req.addr ),
    .rdata_o ( rom_rdata    )
  );

  scratchpad_mem i_scratchpad_mem (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .req_i      ( spm_req    ),
    .tgt_req_i  ( tgt_req    ),
    .rdata_o    ( spm_rdata  )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .tgt_req_i   ( tgt_req     ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o )
  );

  // Debug hold-off after reset
  debug_req_gate i_debug_req_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// ==== memory/scratchpad_mem.sv ====
`timescale 1ns/10ps
`include "soc_config.svh"

module scratchpad_mem (
  input  logic                   clk_i,
  input  logic                   ndmreset_n,
  input  logic                   req_i,
  input  soc_pkg::bus_req_t      tgt_req_i,
  output logic [`SOC_DATA_W-1:0] rdata_o
);
  import soc_pkg::*;

  localparam int unsigned IDX_W = $clog2(`SOC_SPM_WORDS);

  logic [`SOC_DATA_W-1:0] mem [`SOC_SPM_WORDS];
  logic [IDX_W-1:0]       word_idx;

  assign word_idx = tgt_req_i.addr[`SOC_WORD_OFFS_W +: IDX_W];

  // ------------------------------
  // Byte-enable write port
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i && tgt_req_i.we) begin
      for (int unsigned b = 0; b < `SOC_BE_W; b++) begin
        if (tgt_req_i.be[b]) mem[word_idx][8*b +: 8] <= tgt_req_i.wdata[8*b +: 8];
      end
    end
  end

  // Read data held until the next read
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rdata_o <= '0;
    end else if (req_i && !tgt_req_i.we) begin
      rdata_o <= mem[word_idx];
    end
  end

endmodule

// ==== memory/boot_rom.sv ====
`timescale 1ns/10ps
`include "soc_config.svh"

module boot_rom (
  input  logic                   clk_i,
  input  logic                   req_i,
  input  logic [`SOC_ADDR_W-1:0] addr_i,
  output logic [`SOC_DATA_W-1:0] rdata_o
);
  import soc_pkg::*;

  localparam int unsigned IDX_W = $clog2(`SOC_ROM_WORDS);

  logic [IDX_W-1:0] word_idx;

  // ROM window is aligned to its size
  assign word_idx = addr_i[`SOC_WORD_OFFS_W +: IDX_W];

  always_ff @(posedge clk_i) begin
    if (req_i) rdata_o <= boot_rom_table[word_idx];
  end

endmodule

// ==== clint/clint_timer.sv ====
`timescale 1ns/10ps
`include "soc_config.svh"

module clint_timer (
  input  logic                      clk_i,
  input  logic                      ndmreset_n,
  input  logic                      rtc_i,
  input  logic                      req_i,
  input  soc_pkg::bus_req_t         tgt_req_i,
  output logic [`SOC_DATA_W-1:0]    rdata_o,
  output logic [`SOC_NUM_HARTS-1:0] timer_irq_o
);
  import soc_pkg::*;

  logic [1:0]             rtc_sync_q;
  logic                   rtc_prev_q;
  logic                   rtc_div_q;
  logic                   rtc_rise;
  logic [`SOC_DATA_W-1:0] mtime_q;
  logic [`SOC_DATA_W-1:0] mtimecmp_q;
  logic                   sel_cmp;

  // ------------------------------
  // RTC sync and divide by two
  // ------------------------------
  assign rtc_rise = rtc_sync_q[1] & ~rtc_prev_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
      rtc_div_q  <= 1'b0;
      mtime_q    <= '0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      if (rtc_rise) begin
        rtc_div_q <= ~rtc_div_q;
        // mtime ticks when the divider wraps
        if (rtc_div_q) mtime_q <= mtime_q + 1'b1;
      end
    end
  end

  // ------------------------------
  // Register access
  // ------------------------------
  // Offset 8 is mtimecmp, offset 0 is mtime
  assign sel_cmp = tgt_req_i.addr[`SOC_WORD_OFFS_W];

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtimecmp_q <= '1;
      rdata_o    <= '0;
    end else if (req_i) begin
      if (tgt_req_i.we) begin
        // Whole-word write, mtime is read-only
        if (sel_cmp) mtimecmp_q <= tgt_req_i.wdata;
      end else begin
        rdata_o <= sel_cmp ? mtimecmp_q : mtime_q;
      end
    end
  end

  assign timer_irq_o = {`SOC_NUM_HARTS{mtime_q >= mtimecmp_q}};

endmodule

// ==== source/debug_req_gate.sv ====
`timescale 1ns/10ps
`include "soc_config.svh"

module debug_req_gate (
  input  logic                      clk_i,
  input  logic                      ndmreset_n,
  input  logic [`SOC_NUM_HARTS-1:0] debug_req_i,
  output logic [`SOC_NUM_HARTS-1:0] debug_req_o
);

  localparam int unsigned CNT_W = $clog2(`SOC_DMI_DEL_CYCLES + 1);

  logic [CNT_W-1:0] del_cnt_q;

  // Boot code gets a head start before the first debug request
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      del_cnt_q <= CNT_W'(`SOC_DMI_DEL_CYCLES);
    end else if (del_cnt_q != '0) begin
      del_cnt_q <= del_cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (del_cnt_q != '0) ? '0 : debug_req_i;

endmodule

// ==== source/bus_ctrl_fsm.sv ====
`timescale 1ns/10ps
`include "soc_config.svh"

module bus_ctrl_fsm (
  input  logic                   clk_i,
  input  logic                   ndmreset_n,
  input  logic                   req_valid_i,
  input  soc_pkg::bus_req_t      req_i,
  input  soc_pkg::target_e       target_i,
  input  logic                   hit_i,
  input  logic [`SOC_DATA_W-1:0] rom_rdata_i,
  input  logic [`SOC_DATA_W-1:0] clint_rdata_i,
  input  logic [`SOC_DATA_W-1:0] spm_rdata_i,
  output logic                   ready_o,
  output logic                   rsp_valid_o,
  output soc_pkg::bus_rsp_t      rsp_o,
  output soc_pkg::bus_req_t      tgt_req_o,
  output logic                   rom_req_o,
  output logic                   clint_req_o,
  output logic                   spm_req_o
);
  import soc_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    RESPOND
  } state_e;

  state_e   state_q;
  state_e   state_d;
  bus_req_t req_q;
  target_e  target_q;
  logic     hit_q;
  logic     accept;

  assign ready_o     = (state_q == IDLE);
  assign rsp_valid_o = (state_q == RESPOND);
  assign accept      = ready_o & req_valid_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (accept) state_d = ACCESS;
      ACCESS:  state_d = RESPOND;
      RESPOND: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      state_q  <= IDLE;
      target_q <= TGT_ROM;
      hit_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        target_q <= target_i;
        hit_q    <= hit_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) req_q <= req_i;
  end

  // One strobe per access, none on a decode miss
  assign tgt_req_o   = req_q;
  assign rom_req_o   = (state_q == ACCESS) && hit_q && (target_q == TGT_ROM);
  assign clint_req_o = (state_q == ACCESS) && hit_q && (target_q == TGT_CLINT);
  assign spm_req_o   = (state_q == ACCESS) && hit_q && (target_q == TGT_SPM);

  // Writes answer with zero data
  always_comb begin
    rsp_o = '0;
    if (state_q == RESPOND) begin
      if (!hit_q) begin
        rsp_o.err = 1'b1;
      end else if (!req_q.we) begin
        unique case (target_q)
          TGT_ROM:   rsp_o.rdata = rom_rdata_i;
          TGT_CLINT: rsp_o.rdata = clint_rdata_i;
          TGT_SPM:   rsp_o.rdata = spm_rdata_i;
          default:   rsp_o.rdata = '0;
        endcase
      end
    end
  end

endmodule

// ==== source/addr_decoder.sv ====
`timescale 1ns/10ps
`include "soc_config.svh"

module addr_decoder (
  input  logic [`SOC_ADDR_W-1:0] addr_i,
  output soc_pkg::target_e       target_o,
  output logic                   hit_o
);
  import soc_pkg::*;

  logic [`SOC_ADDR_W-1:0] word_addr;

  // Byte offset inside the word plays no part in decoding
  assign word_addr = {addr_i[`SOC_ADDR_W-1:`SOC_WORD_OFFS_W], {`SOC_WORD_OFFS_W{1'b0}}};

  // ------------------------------
  // Rule scan
  // ------------------------------
  always_comb begin
    target_o = TGT_ROM;
    hit_o    = 1'b0;
    for (int unsigned i = 0; i < NUM_RULES; i++) begin
      if ((word_addr >= addr_map[i].start_addr) && (word_addr < addr_map[i].end_addr)) begin
        target_o = addr_map[i].idx;
        hit_o    = 1'b1;
      end
    end
  end

endmodule

// ==== common/soc_pkg.sv ====
`include "soc_config.svh"

package soc_pkg;

  // One bus request as issued by the master
  typedef struct packed {
    logic                   we;
    logic [`SOC_ADDR_W-1:0] addr;
    logic [`SOC_DATA_W-1:0] wdata;
    logic [`SOC_BE_W-1:0]   be;
  } bus_req_t;

  typedef struct packed {
    logic [`SOC_DATA_W-1:0] rdata;
    logic                   err;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_CLINT,
    TGT_SPM
  } target_e;

  // End address is exclusive
  typedef struct packed {
    target_e                idx;
    logic [`SOC_ADDR_W-1:0] start_addr;
    logic [`SOC_ADDR_W-1:0] end_addr;
  } addr_rule_t;

  localparam int unsigned NUM_RULES = 3;

  localparam addr_rule_t addr_map [NUM_RULES] = '{
    '{idx: TGT_ROM,   start_addr: `SOC_ROM_BASE,   end_addr: `SOC_ROM_BASE + `SOC_ROM_LEN},
    '{idx: TGT_CLINT, start_addr: `SOC_CLINT_BASE, end_addr: `SOC_CLINT_BASE + `SOC_CLINT_LEN},
    '{idx: TGT_SPM,   start_addr: `SOC_SPM_BASE,   end_addr: `SOC_SPM_BASE + `SOC_SPM_LEN}
  };

  // Boot code image, two instructions per word
  localparam logic [`SOC_DATA_W-1:0] boot_rom_table [`SOC_ROM_WORDS] = '{
    64'h0000_0297_F140_2573,
    64'h0202_B583_0182_B283,
    64'h0000_0013_0002_8067,
    64'h1C00_0137_0000_0013,
    64'h0001_0113_8001_0113,
    64'h0000_0513_0000_0593,
    64'h1050_0073_0000_006F,
    64'h0000_0000_1C00_0000,
    64'h0000_0000_8000_0000,
    64'hDEAD_BEEF_0BAD_F00D,
    64'h0123_4567_89AB_CDEF,
    64'hFEDC_BA98_7654_3210,
    64'h5555_AAAA_3333_CCCC,
    64'h0F0F_F0F0_00FF_FF00,
    64'h7FFF_FFFF_8000_0001,
    64'hC0DE_CAFE_0000_0001
  };

endpackage

// ==== common/soc_config.svh ====
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// ------------------------------
// Bus geometry
// ------------------------------
`define SOC_DATA_W 64
`define SOC_ADDR_W 32
`define SOC_BE_W (`SOC_DATA_W / 8)
// Byte offset bits inside one bus word
`define SOC_WORD_OFFS_W $clog2(`SOC_DATA_W / 8)

// Harts fed with debug requests and timer interrupts
`define SOC_NUM_HARTS 2

// Cycles after reset before a debug request may reach a hart
`define SOC_DMI_DEL_CYCLES 500

// ------------------------------
// Address map
// ------------------------------
`define SOC_ROM_BASE 32'h0001_0000
`define SOC_ROM_LEN 32'h0000_0080
`define SOC_CLINT_BASE 32'h0200_0000
`define SOC_CLINT_LEN 32'h0000_0010
`define SOC_SPM_BASE 32'h1C00_0000
`define SOC_SPM_LEN 32'h0000_0800

// Memory depths in bus words
`define SOC_ROM_WORDS (`SOC_ROM_LEN / `SOC_BE_W)
`define SOC_SPM_WORDS (`SOC_SPM_LEN / `SOC_BE_W)

`endif
